/* roce_tx_top.f */
+incdir+verification
verilog/roce_pkg.sv
verilog/qp_cfg_regs.sv
verilog/roce_pkt_gen.sv
verilog/icrc_append.sv
verilog/roce_pkt_filter.sv
verilog/roce_tx_top.sv
verification/roce_tx_tb.sv

/* Makefile */
VERILATOR ?= verilator
VFLAGS    ?= --binary --timing --assert -Wno-fatal
TOP       := roce_tx_tb
FILELIST  := roce_tx_top.f
OBJ_DIR   := obj_dir
LOG       := sim.log

.PHONY: help test clean

help:
	@echo "Targets:"
	@echo "  test   build with Verilator, run the testbench, check $(LOG)"
	@echo "  clean  remove $(OBJ_DIR) and $(LOG)"
	@echo "  help   list these targets"

test:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(OBJ_DIR) -o $(TOP)_sim
	-./$(OBJ_DIR)/$(TOP)_sim > $(LOG) 2>&1
	@cat $(LOG)
	@if grep -q "RESULT: FAIL" $(LOG) || ! grep -q "RESULT: PASS" $(LOG); then \
		echo "Simulation failed"; exit 1; \
	fi
	@echo "Simulation passed"

clean:
	rm -rf $(OBJ_DIR) $(LOG)

/* verification/roce_tx_tb_cases.svh */
`ifndef ROCE_TX_TB_CASES_SVH
`define ROCE_TX_TB_CASES_SVH

// Each row holds opcode, queue pair, payload beats and whether a packet reaches o_tx
typedef struct packed {
    logic [7:0] opcode;
    logic [7:0] qp;
    logic [7:0] len;
    logic       pass;
} case_t;

localparam int          NUM_CASES  = 18;
localparam int          RELOAD_ROW = 10;        // qp 0 start PSN rewritten before this row
localparam logic [23:0] RELOAD_PSN = 24'h00ABC0;

localparam case_t CASES [NUM_CASES] = '{
    '{8'h04, 8'd0, 8'd3,  1'b1},
    '{8'h10, 8'd1, 8'd1,  1'b1},
    '{8'h11, 8'd2, 8'd0,  1'b1},  // Empty ack gives CRC 0
    '{8'h04, 8'd1, 8'd2,  1'b1},
    '{8'h04, 8'd1, 8'd0,  1'b1},  // PSN wraps to 0
    '{8'h20, 8'd0, 8'd2,  1'b0},  // Unsupported
    '{8'h04, 8'd0, 8'd4,  1'b1},
    '{8'h04, 8'd3, 8'd2,  1'b0},  // qp 3 never valid
    '{8'h10, 8'd2, 8'd5,  1'b1},
    '{8'h11, 8'd0, 8'd0,  1'b1},
    '{8'h04, 8'd0, 8'd1,  1'b1},
    '{8'h10, 8'd0, 8'd2,  1'b1},
    '{8'h64, 8'd2, 8'd1,  1'b0},
    '{8'h04, 8'd2, 8'd7,  1'b1},
    '{8'h11, 8'd1, 8'd0,  1'b1},
    '{8'h10, 8'd5, 8'd3,  1'b0},  // Beyond NUM_QP
    '{8'h04, 8'd0, 8'd40, 1'b1},
    '{8'h0A, 8'd1, 8'd1,  1'b0}
};

`endif

/* verification/roce_tx_tb.sv */
module roce_tx_tb;

    localparam int NUM_QP = 4;

    `include "roce_tx_tb_cases.svh"

    // Reset, config writes and the closing stats poll
    localparam int SETUP_CYCLES = 20 * 8 + 250;
    localparam int LIMIT_CYCLES = NUM_CASES * 300 + SETUP_CYCLES;

    logic                aclk;
    logic                aresetn;
    roce_pkg::cfg_wr_t   cfg;
    logic                cfg_req;
    logic                cfg_ack;
    roce_pkg::send_cmd_t cmd;
    logic                cmd_req;
    logic                cmd_ack;
    roce_pkg::beat_t     tx;
    logic                tx_valid;
    logic                tx_ready;
    roce_pkg::stats_t    stats;

    integer seed = 93;
    int     err_cnt = 0;
    int     check_cnt = 0;
    int     beat_cnt = 0;

    // Reference model
    logic [47:0]      m_mac   [256];
    logic [31:0]      m_ip    [256];
    logic [23:0]      m_psn   [256];
    logic             m_valid [256];
    roce_pkg::beat_t  exp_q   [$];
    roce_pkg::stats_t exp_stats;

    roce_tx_top #(
        .NUM_QP (NUM_QP)
    ) dut_i (
        .aclk       (aclk),
        .aresetn    (aresetn),
        .i_cfg      (cfg),
        .i_cfg_req  (cfg_req),
        .o_cfg_ack  (cfg_ack),
        .i_cmd      (cmd),
        .i_cmd_req  (cmd_req),
        .o_cmd_ack  (cmd_ack),
        .o_tx       (tx),
        .o_tx_valid (tx_valid),
        .i_tx_ready (tx_ready),
        .o_stats    (stats)
    );

    always #5 aclk = ~aclk;

    task automatic compare_value(input string name, input logic [72:0] exp,
                                 input logic [72:0] act);
        check_cnt++;
        if (exp !== act) begin
            err_cnt++;
            $display("** Error %s: expected %h, actual %h", name, exp, act);
        end
    endtask

    // Bit serial from the LSB of each beat
    function automatic logic [31:0] crc32_update(input logic [31:0] crc,
                                                 input logic [63:0] data);
        logic [31:0] c;
        logic        fb;
        c = crc;
        for (int i = 0; i < 64; i++) begin
            fb = c[0] ^ data[i];
            c = c >> 1;
            if (fb) begin
                c = c ^ 32'hEDB88320;
            end
        end
        return c;
    endfunction

    task automatic write_cfg(input logic [7:0] addr, input logic [31:0] data);
        int q;
        q = int'(addr[7:2]);
        @(negedge aclk);
        cfg.addr = addr;
        cfg.data = data;
        cfg_req  = 1'b1;
        while (!cfg_ack) @(negedge aclk);
        cfg_req = 1'b0;
        while (cfg_ack) @(negedge aclk);
        if (int'(addr) < NUM_QP * 4) begin
            case (addr[1:0])
                2'd0: m_mac[q][31:0] = data;
                2'd1: m_mac[q][47:32] = data[15:0];
                2'd2: m_ip[q] = data;
                default: begin
                    m_valid[q] = data[31];
                    m_psn[q]   = data[23:0];
                end
            endcase
        end
    endtask

    task automatic setup_qp(input int qp, input logic [47:0] mac, input logic [31:0] ip,
                            input logic [23:0] psn);
        write_cfg(8'(qp * 4), mac[31:0]);
        write_cfg(8'(qp * 4 + 1), {16'd0, mac[47:32]});
        write_cfg(8'(qp * 4 + 2), ip);
        write_cfg(8'(qp * 4 + 3), {1'b1, 7'd0, psn});
    endtask

    task automatic predict(input case_t row);
        logic [31:0]     crc;
        logic [23:0]     psn;
        roce_pkg::beat_t b;
        if (!m_valid[row.qp]) begin
            return;
        end
        psn = m_psn[row.qp];
        m_psn[row.qp] = psn + 24'd1;
        case (row.opcode)
            roce_pkg::OP_SEND_ONLY:    exp_stats.send_cnt = exp_stats.send_cnt + 16'd1;
            roce_pkg::OP_RD_RESP_ONLY: exp_stats.rd_resp_cnt = exp_stats.rd_resp_cnt + 16'd1;
            roce_pkg::OP_ACK:          exp_stats.ack_cnt = exp_stats.ack_cnt + 16'd1;
            default:                   exp_stats.drop_cnt = exp_stats.drop_cnt + 16'd1;
        endcase
        if (!row.pass) begin
            return;
        end
        b.keep = 8'hFF;
        b.last = 1'b0;
        b.data = {m_mac[row.qp], row.opcode, row.qp};
        exp_q.push_back(b);
        b.data = {m_ip[row.qp], psn, row.len};
        exp_q.push_back(b);
        crc = 32'hFFFFFFFF;
        for (int k = 0; k < int'(row.len); k++) begin
            b.data = {psn, row.qp, 32'(k)};
            exp_q.push_back(b);
            crc = crc32_update(crc, b.data);
        end
        b.data = {32'd0, ~crc};
        b.keep = 8'h0F;
        b.last = 1'b1;
        exp_q.push_back(b);
    endtask

    task automatic send_cmd(input case_t row);
        @(negedge aclk);
        cmd.opcode = roce_pkg::opcode_e'(row.opcode);
        cmd.qp     = row.qp;
        cmd.len    = row.len;
        cmd_req    = 1'b1;
        while (!cmd_ack) @(negedge aclk);
        cmd_req = 1'b0;
        while (cmd_ack) @(negedge aclk);
    endtask

    task automatic drain_tx();
        while (exp_q.size() != 0) @(negedge aclk);
    endtask

    always @(negedge aclk) begin
        if (aresetn) begin
            tx_ready = ($random(seed) & 3) != 0; // Ready about 3 cycles in 4
        end
    end

    always @(posedge aclk) begin
        if (aresetn && tx_valid && tx_ready) begin
            if (exp_q.size() == 0) begin
                err_cnt++;
                $display("Error: o_tx delivered a beat while no beat was expected: %h", tx);
            end else begin
                compare_value($sformatf("o_tx beat %0d", beat_cnt), exp_q.pop_front(), tx);
            end
            beat_cnt++;
        end
    end

    initial begin
        repeat (LIMIT_CYCLES) @(posedge aclk);
        $display("Timeout: run did not finish within %0d cycles, %0d checks done, errors: %0d",
                 LIMIT_CYCLES, check_cnt, err_cnt);
        $display("RESULT: FAIL");
        $finish;
    end

    initial begin
        aclk      = 1'b0;
        aresetn   = 1'b0;
        cfg       = '0;
        cfg_req   = 1'b0;
        cmd       = '0;
        cmd_req   = 1'b0;
        tx_ready  = 1'b1;
        exp_stats = '0;
        for (int q = 0; q < 256; q++) begin
            m_mac[q]   = '0;
            m_ip[q]    = '0;
            m_psn[q]   = '0;
            m_valid[q] = 1'b0;
        end
        repeat (2) @(posedge aclk);
        @(negedge aclk);
        aresetn = 1'b1;

        compare_value("cfg_ack after reset", 1'b0, cfg_ack);
        compare_value("cmd_ack after reset", 1'b0, cmd_ack);
        compare_value("tx_valid after reset", 1'b0, tx_valid);
        compare_value("stats after reset", '0, stats);

        setup_qp(0, 48'h02_00_00_00_00_10, 32'hC0A8_0010, 24'h000100);
        setup_qp(1, 48'h02_00_00_00_00_11, 32'hC0A8_0011, 24'hFFFFFE);
        setup_qp(2, 48'h02_00_00_00_00_12, 32'hC0A8_0012, 24'h000500);
        write_cfg(8'h43, 32'h8000_0077);  // Beyond NUM_QP so acked and ignored

        for (int r = 0; r < NUM_CASES; r++) begin
            if (r == RELOAD_ROW) begin
                drain_tx();
                write_cfg(8'h03, {1'b1, 7'd0, RELOAD_PSN});
            end
            predict(CASES[r]);
            send_cmd(CASES[r]);
        end
        drain_tx();

        // Trailing dropped packets still count after the last o_tx beat
        for (int n = 0; n < 200 && stats !== exp_stats; n++) @(negedge aclk);
        compare_value("send count", exp_stats.send_cnt, stats.send_cnt);
        compare_value("read response count", exp_stats.rd_resp_cnt, stats.rd_resp_cnt);
        compare_value("ack count", exp_stats.ack_cnt, stats.ack_cnt);
        compare_value("drop count", exp_stats.drop_cnt, stats.drop_cnt);

        $display("Checks: %0d, o_tx beats: %0d, errors: %0d", check_cnt, beat_cnt, err_cnt);
        if (err_cnt == 0) begin
            $display("RESULT: PASS");
        end else begin
            $display("RESULT: FAIL");
        end
        $finish;
    end

endmodule

/* verilog/roce_tx_top.sv */
module roce_tx_top #(
    parameter int NUM_QP = 4
) (
    input  logic                      aclk,
    input  logic                      aresetn,
    input  roce_pkg::cfg_wr_t         i_cfg,
    input  logic                      i_cfg_req,
    output logic                      o_cfg_ack,
    input  roce_pkg::send_cmd_t       i_cmd,
    input  logic                      i_cmd_req,
    output logic                      o_cmd_ack,
    output roce_pkg::beat_t           o_tx,
    output logic                      o_tx_valid,
    input  logic                      i_tx_ready,
    output roce_pkg::stats_t          o_stats
);

    roce_pkg::qp_cfg_t [NUM_QP-1:0] qp_cfg;
    logic                           psn_inc;
    logic [roce_pkg::QP_W-1:0]      psn_qp;

    // Generator to CRC stage
    roce_pkg::beat_t gen_beat;
    logic            gen_valid;
    logic            gen_ready;

    // CRC stage to filter
    roce_pkg::beat_t crc_beat;
    logic            crc_valid;
    logic            crc_ready;

    qp_cfg_regs #(
        .NUM_QP (NUM_QP)
    ) qp_cfg_regs_i (
        .aclk      (aclk),
        .aresetn   (aresetn),
        .i_cfg     (i_cfg),
        .i_cfg_req (i_cfg_req),
        .i_psn_inc (psn_inc),
        .i_psn_qp  (psn_qp),
        .o_cfg_ack (o_cfg_ack),
        .o_qp_cfg  (qp_cfg)
    );

    roce_pkt_gen #(
        .NUM_QP (NUM_QP)
    ) roce_pkt_gen_i (
        .aclk      (aclk),
        .aresetn   (aresetn),
        .i_cmd     (i_cmd),
        .i_cmd_req (i_cmd_req),
        .i_qp_cfg  (qp_cfg),
        .i_ready   (gen_ready),
        .o_cmd_ack (o_cmd_ack),
        .o_psn_inc (psn_inc),
        .o_psn_qp  (psn_qp),
        .o_beat    (gen_beat),
        .o_valid   (gen_valid)
    );

    icrc_append icrc_append_i (
        .aclk    (aclk),
        .aresetn (aresetn),
        .i_beat  (gen_beat),
        .i_valid (gen_valid),
        .i_ready (crc_ready),
        .o_ready (gen_ready),
        .o_beat  (crc_beat),
        .o_valid (crc_valid)
    );

    roce_pkt_filter roce_pkt_filter_i (
        .aclk    (aclk),
        .aresetn (aresetn),
        .i_beat  (crc_beat),
        .i_valid (crc_valid),
        .i_ready (i_tx_ready),
        .o_ready (crc_ready),
        .o_beat  (o_tx),
        .o_valid (o_tx_valid),
        .o_stats (o_stats)
    );

endmodule

/* verilog/roce_pkt_filter.sv */
module roce_pkt_filter (
    input  logic             aclk,
    input  logic             aresetn,
    input  roce_pkg::beat_t  i_beat,
    input  logic             i_valid,
    input  logic             i_ready,
    output logic             o_ready,
    output roce_pkg::beat_t  o_beat,
    output logic             o_valid,
    output roce_pkg::stats_t o_stats
);

    roce_pkg::stats_t stats_q;

    logic in_pkt;    // Past the first beat of a packet
    logic pass_q;
    logic pass_now;
    logic pass_dec;
    logic in_xfer;
    logic out_sop;   // o_beat holds a packet's first beat

    function automatic logic [15:0] sat_inc(input logic [15:0] v);
        return (v == 16'hFFFF) ? v : v + 16'd1;
    endfunction

    always_comb begin
        case (i_beat.data[15:8])
            roce_pkg::OP_SEND_ONLY,
            roce_pkg::OP_RD_RESP_ONLY,
            roce_pkg::OP_ACK: pass_now = 1'b1;
            default:          pass_now = 1'b0;
        endcase
    end

    assign pass_dec = in_pkt ? pass_q : pass_now;
    assign o_ready  = !o_valid || i_ready;
    assign in_xfer  = i_valid && o_ready;
    assign o_stats  = stats_q;

    always_ff @(posedge aclk or negedge aresetn) begin
        if (!aresetn) begin
            in_pkt  <= 1'b0;
            pass_q  <= 1'b0;
            o_valid <= 1'b0;
            stats_q <= '0;
        end else begin
            if (o_ready) begin
                o_valid <= in_xfer && pass_dec; // Dropped beats vanish here
            end
            if (in_xfer) begin
                in_pkt <= !i_beat.last;
                if (!in_pkt) begin
                    pass_q <= pass_now;
                    case (i_beat.data[15:8])
                        roce_pkg::OP_SEND_ONLY:
                            stats_q.send_cnt <= sat_inc(stats_q.send_cnt);
                        roce_pkg::OP_RD_RESP_ONLY:
                            stats_q.rd_resp_cnt <= sat_inc(stats_q.rd_resp_cnt);
                        roce_pkg::OP_ACK:
                            stats_q.ack_cnt <= sat_inc(stats_q.ack_cnt);
                        default:
                            stats_q.drop_cnt <= sat_inc(stats_q.drop_cnt);
                    endcase
                end
            end
        end
    end

    always_ff @(posedge aclk) begin
        if (in_xfer && pass_dec) begin
            o_beat  <= i_beat;
            out_sop <= !in_pkt;
        end
    end

    // Every forwarded packet starts with a supported opcode
    a_no_fwd_on_drop: assert property (
        @(posedge aclk) disable iff (!aresetn)
        o_valid && out_sop |-> (o_beat.data[15:8] == roce_pkg::OP_SEND_ONLY ||
                                o_beat.data[15:8] == roce_pkg::OP_RD_RESP_ONLY ||
                                o_beat.data[15:8] == roce_pkg::OP_ACK)
    );

endmodule

/* verilog/icrc_append.sv */
module icrc_append (
    input  logic            aclk,
    input  logic            aresetn,
    input  roce_pkg::beat_t i_beat,
    input  logic            i_valid,
    input  logic            i_ready,
    output logic            o_ready,
    output roce_pkg::beat_t o_beat,
    output logic            o_valid
);

    localparam logic [31:0] CRC_POLY = 32'hEDB88320;
    localparam logic [31:0] CRC_INIT = 32'hFFFFFFFF;

    logic [31:0] crc_q;
    logic [1:0]  hdr_cnt;   // Saturates at 2 once past the headers
    logic        crc_pend;
    logic        load_ok;
    logic        is_payload;

    // Reflected CRC-32 over the kept bytes from byte 0 up
    function automatic logic [31:0] crc_beat(
        input logic [31:0]                 crc_in,
        input logic [roce_pkg::DATA_W-1:0] data,
        input logic [roce_pkg::KEEP_W-1:0] keep
    );
        logic [31:0] c;
        c = crc_in;
        for (int b = 0; b < roce_pkg::KEEP_W; b++) begin
            if (keep[b]) begin
                c = c ^ {24'd0, data[8*b +: 8]};
                for (int i = 0; i < 8; i++) begin
                    c = c[0] ? ((c >> 1) ^ CRC_POLY) : (c >> 1);
                end
            end
        end
        return c;
    endfunction

    assign load_ok    = !o_valid || i_ready;
    assign o_ready    = load_ok && !crc_pend; // Input held off during CRC beat
    assign is_payload = hdr_cnt == 2'd2;

    always_ff @(posedge aclk or negedge aresetn) begin
        if (!aresetn) begin
            o_valid  <= 1'b0;
            crc_pend <= 1'b0;
            hdr_cnt  <= '0;
            crc_q    <= CRC_INIT;
        end else if (load_ok) begin
            if (crc_pend) begin
                o_valid  <= 1'b1;
                crc_pend <= 1'b0;
                crc_q    <= CRC_INIT;
            end else if (i_valid) begin
                o_valid <= 1'b1;
                if (is_payload) begin
                    crc_q <= crc_beat(crc_q, i_beat.data, i_beat.keep);
                end
                if (i_beat.last) begin
                    crc_pend <= 1'b1;
                    hdr_cnt  <= '0;
                end else if (!is_payload) begin
                    hdr_cnt <= hdr_cnt + 2'd1;
                end
            end else begin
                o_valid <= 1'b0;
            end
        end
    end

    always_ff @(posedge aclk) begin
        if (load_ok) begin
            if (crc_pend) begin
                o_beat.data <= {32'd0, ~crc_q}; // Final inversion
                o_beat.keep <= 8'h0F;
                o_beat.last <= 1'b1;
            end else if (i_valid) begin
                o_beat.data <= i_beat.data;
                o_beat.keep <= i_beat.keep;
                o_beat.last <= 1'b0;
            end
        end
    end

endmodule

/* verilog/roce_pkt_gen.sv */
module roce_pkt_gen #(
    parameter int NUM_QP = 4
) (
    input  logic                            aclk,
    input  logic                            aresetn,
    input  roce_pkg::send_cmd_t             i_cmd,
    input  logic                            i_cmd_req,
    input  roce_pkg::qp_cfg_t [NUM_QP-1:0]  i_qp_cfg,
    input  logic                            i_ready,
    output logic                            o_cmd_ack,
    output logic                            o_psn_inc,
    output logic [roce_pkg::QP_W-1:0]       o_psn_qp,
    output roce_pkg::beat_t                 o_beat,
    output logic                            o_valid
);

    typedef enum logic [1:0] {
        S_IDLE,
        S_HDR0,
        S_HDR1,
        S_PAY
    } state_e;

    state_e                     state;
    logic [7:0]                 beat_cnt;
    roce_pkg::send_cmd_t        cmd_q;
    logic [47:0]                mac_q;
    logic [31:0]                ip_q;
    logic [roce_pkg::PSN_W-1:0] psn_q;

    roce_pkg::qp_cfg_t cmd_cfg;
    logic              cmd_take;
    logic              xfer;
    logic              pay_last;

    // Out of range queue pairs read as invalid
    assign cmd_cfg  = (i_cmd.qp < NUM_QP) ? i_qp_cfg[i_cmd.qp] : '0;
    assign cmd_take = (state == S_IDLE) && i_cmd_req && !o_cmd_ack;
    assign xfer     = o_valid && i_ready;
    assign pay_last = beat_cnt == cmd_q.len - 8'd1;

    assign o_valid   = state != S_IDLE;
    assign o_psn_inc = (state == S_HDR0) && i_ready; // Header 0 accepted
    assign o_psn_qp  = cmd_q.qp;

    always_ff @(posedge aclk or negedge aresetn) begin
        if (!aresetn) begin
            state     <= S_IDLE;
            beat_cnt  <= '0;
            o_cmd_ack <= 1'b0;
        end else begin
            if (!o_cmd_ack) begin
                o_cmd_ack <= cmd_take;
            end else begin
                o_cmd_ack <= i_cmd_req;
            end
            case (state)
                S_IDLE: if (cmd_take && cmd_cfg.valid) state <= S_HDR0;
                S_HDR0: if (xfer) state <= S_HDR1;
                S_HDR1: begin
                    if (xfer) begin
                        beat_cnt <= '0;
                        state    <= (cmd_q.len == 8'd0) ? S_IDLE : S_PAY;
                    end
                end
                default: begin
                    if (xfer) begin
                        beat_cnt <= beat_cnt + 8'd1;
                        if (pay_last) state <= S_IDLE;
                    end
                end
            endcase
        end
    end

    // Snapshot so a later config write cannot tear a packet
    always_ff @(posedge aclk) begin
        if (cmd_take) begin
            cmd_q <= i_cmd;
            mac_q <= cmd_cfg.dst_mac;
            ip_q  <= cmd_cfg.dst_ip;
            psn_q <= cmd_cfg.psn;
        end
    end

    always_comb begin
        o_beat.keep = '1;
        o_beat.last = 1'b0;
        o_beat.data = '0;
        case (state)
            S_HDR0: o_beat.data = {mac_q, cmd_q.opcode, cmd_q.qp};
            S_HDR1: begin
                o_beat.data = {ip_q, psn_q, cmd_q.len};
                o_beat.last = cmd_q.len == 8'd0;
            end
            S_PAY: begin
                o_beat.data = {psn_q, cmd_q.qp, 24'd0, beat_cnt};
                o_beat.last = pay_last;
            end
            default: ;
        endcase
    end

    a_beat_hold: assert property (
        @(posedge aclk) disable iff (!aresetn)
        o_valid && !i_ready |=> o_valid && $stable(o_beat)
    );

endmodule

/* verilog/qp_cfg_regs.sv */
module qp_cfg_regs #(
    parameter int NUM_QP = 4
) (
    input  logic                                aclk,
    input  logic                                aresetn,
    input  roce_pkg::cfg_wr_t                   i_cfg,
    input  logic                                i_cfg_req,
    input  logic                                i_psn_inc,
    input  logic [roce_pkg::QP_W-1:0]           i_psn_qp,
    output logic                                o_cfg_ack,
    output roce_pkg::qp_cfg_t [NUM_QP-1:0]      o_qp_cfg
);

    localparam int ADDR_LIMIT = NUM_QP * 4;

    logic [47:0]               mac_q   [NUM_QP];
    logic [31:0]               ip_q    [NUM_QP];
    logic [roce_pkg::PSN_W-1:0] psn_q  [NUM_QP];
    logic [NUM_QP-1:0]         valid_q;

    logic       wr_en;
    logic [5:0] wr_qp;
    logic [1:0] wr_word;

    // Write lands on the edge where ack rises
    assign wr_en   = i_cfg_req && !o_cfg_ack && (i_cfg.addr < ADDR_LIMIT);
    assign wr_qp   = i_cfg.addr[7:2];
    assign wr_word = i_cfg.addr[1:0];

    always_ff @(posedge aclk or negedge aresetn) begin
        if (!aresetn) begin
            o_cfg_ack <= 1'b0;
            valid_q   <= '0;
        end else begin
            o_cfg_ack <= i_cfg_req; // Follows each request edge
            for (int q = 0; q < NUM_QP; q++) begin
                if (wr_en && wr_qp == q && wr_word == roce_pkg::CFG_PSN) begin
                    valid_q[q] <= i_cfg.data[31];
                end
            end
        end
    end

    always_ff @(posedge aclk) begin
        for (int q = 0; q < NUM_QP; q++) begin
            if (wr_en && wr_qp == q) begin
                case (wr_word)
                    roce_pkg::CFG_MAC_LO: mac_q[q][31:0]  <= i_cfg.data;
                    roce_pkg::CFG_MAC_HI: mac_q[q][47:32] <= i_cfg.data[15:0];
                    roce_pkg::CFG_IP:     ip_q[q]         <= i_cfg.data;
                    default:              psn_q[q]        <= i_cfg.data[23:0];
                endcase
            end
            // Reload beats increment
            if (i_psn_inc && i_psn_qp == q &&
                !(wr_en && wr_qp == q && wr_word == roce_pkg::CFG_PSN)) begin
                psn_q[q] <= psn_q[q] + 1'b1;
            end
        end
    end

    always_comb begin
        for (int q = 0; q < NUM_QP; q++) begin
            o_qp_cfg[q].dst_mac = mac_q[q];
            o_qp_cfg[q].dst_ip  = ip_q[q];
            o_qp_cfg[q].psn     = psn_q[q];
            o_qp_cfg[q].valid   = valid_q[q];
        end
    end

    // Host must hold req until it sees ack
    a_req_held_until_ack: assert property (
        @(posedge aclk) disable iff (!aresetn)
        $fell(i_cfg_req) |-> o_cfg_ack
    );

endmodule

/* verilog/roce_pkg.sv */
package roce_pkg;

    // Stream beat geometry
    localparam int DATA_W = 64;
    localparam int KEEP_W = DATA_W / 8;

    localparam int QP_W  = 8;
    localparam int PSN_W = 24;

    // Word index inside one queue pair's four-word window
    localparam logic [1:0] CFG_MAC_LO = 2'd0;
    localparam logic [1:0] CFG_MAC_HI = 2'd1;
    localparam logic [1:0] CFG_IP     = 2'd2;
    localparam logic [1:0] CFG_PSN    = 2'd3; // Valid in bit 31 above the start PSN

    typedef enum logic [7:0] {
        OP_SEND_ONLY    = 8'h04,
        OP_RD_RESP_ONLY = 8'h10,
        OP_ACK          = 8'h11
    } opcode_e;

    typedef struct packed {
        logic [7:0]  addr;  // qp * 4 + word
        logic [31:0] data;
    } cfg_wr_t;

    typedef struct packed {
        logic [47:0]      dst_mac;
        logic [31:0]      dst_ip;
        logic [PSN_W-1:0] psn;
        logic             valid;
    } qp_cfg_t;

    typedef struct packed {
        opcode_e         opcode;
        logic [QP_W-1:0] qp;
        logic [7:0]      len;  // Payload beats
    } send_cmd_t;

    typedef struct packed {
        logic [DATA_W-1:0] data;
        logic [KEEP_W-1:0] keep;
        logic              last;
    } beat_t;

    typedef struct packed {
        logic [15:0] send_cnt;
        logic [15:0] rd_resp_cnt;
        logic [15:0] ack_cnt;
        logic [15:0] drop_cnt;
    } stats_t;

endpackage
